// File: source/fifo_demo_defs.svh
`ifndef FIFO_DEMO_DEFS_SVH
`define FIFO_DEMO_DEFS_SVH

// fifo geometry, depth is 2**FIFO_ABITS words
`define FIFO_ABITS 4
`define FIFO_DBITS 8 // one switch per data bit

// stable sampled cycles before a new button level counts
// short value suits simulation, a board at 50 MHz wants a few hundred thousand
`define DEBOUNCE_CYCLES 8

// flops in front of the debounce fsm
`define SYNC_STAGES 2

`endif

// File: source/fifo_demo_pkg.sv
`default_nettype none

`include "fifo_demo_defs.svh"

package fifo_demo_pkg;

  // debounce fsm, accepted level is low in the first two and high in the last two
  typedef enum logic [1:0] {
    IDLE,         // released and stable
    PRESS_WAIT,   // level went high, waiting for it to settle
    HELD,         // pressed and stable
    RELEASE_WAIT  // level went low, waiting for it to settle
  } debounce_state_t;

  // operation actually carried out this cycle
  typedef enum logic [1:0] {
    OP_NONE,
    OP_PUSH,
    OP_POP,
    OP_PUSH_POP
  } fifo_op_t;

  // one-cycle pulses from the two button one-shots
  typedef struct packed {
    logic push;
    logic pop;
  } button_events_t;

  typedef struct packed {
    logic                 empty;
    logic                 full;
    logic [`FIFO_ABITS:0] count; // 0 up to depth inclusive
  } fifo_status_t;

endpackage

`default_nettype wire

// File: source/debounce_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_demo_defs.svh"

module debounce_timer (
  input  logic clock,
  input  logic reset,
  input  logic clear, // level agrees with the accepted one, or a change was just taken
  output logic done   // level has been different for DEBOUNCE_CYCLES samples
);

  localparam int cnt_bits = $clog2(`DEBOUNCE_CYCLES + 1);
  localparam logic [cnt_bits-1:0] cnt_max = cnt_bits'(`DEBOUNCE_CYCLES);

  logic [cnt_bits-1:0] count;

  // saturates at cnt_max so done stays up until the next clear
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      count <= '0;
    end
    else if (clear)
    begin
      count <= '0;
    end
    else if (!done)
    begin
      count <= count + 1'b1;
    end
  end

  assign done = (count == cnt_max);

endmodule

`default_nettype wire

// File: source/button_oneshot.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_demo_defs.svh"

module button_oneshot (
  input  logic clock,
  input  logic reset,
  input  logic button, // raw, asynchronous, bouncy
  output logic pulse   // one clock wide per accepted press
);

  logic [`SYNC_STAGES-1:0]         sync_q;
  logic                            btn_sync;
  fifo_demo_pkg::debounce_state_t  state;
  fifo_demo_pkg::debounce_state_t  state_next;
  logic                            accepted;     // debounced level implied by the state
  logic                            level_differs;
  logic                            accept;       // a pending change settles this cycle
  logic                            timer_clear;
  logic                            timer_done;

  // shift register synchronizer, oldest sample at the top
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      sync_q <= '0;
    else
      sync_q <= {sync_q[`SYNC_STAGES-2:0], button};
  end

  assign btn_sync = sync_q[`SYNC_STAGES-1];

  assign accepted      = (state == fifo_demo_pkg::HELD) ||
                         (state == fifo_demo_pkg::RELEASE_WAIT);
  assign level_differs = (btn_sync != accepted);
  assign accept        = level_differs && timer_done &&
                         ((state == fifo_demo_pkg::PRESS_WAIT) ||
                          (state == fifo_demo_pkg::RELEASE_WAIT));
  // restart on agreement, and also right after a change is taken so the next one starts from 0
  assign timer_clear   = !level_differs || accept;

  debounce_timer debounce_timer_i (
    .clock (clock),
    .reset (reset),
    .clear (timer_clear),
    .done  (timer_done)
  );

  always_comb
  begin
    state_next = state;
    unique case (state)
      fifo_demo_pkg::IDLE:
        if (level_differs) state_next = fifo_demo_pkg::PRESS_WAIT;
      fifo_demo_pkg::PRESS_WAIT:
        if (!level_differs)
          state_next = fifo_demo_pkg::IDLE; // bounce, fall back
        else if (accept)
          state_next = fifo_demo_pkg::HELD;
      fifo_demo_pkg::HELD:
        if (level_differs) state_next = fifo_demo_pkg::RELEASE_WAIT;
      fifo_demo_pkg::RELEASE_WAIT:
        if (!level_differs)
          state_next = fifo_demo_pkg::HELD; // still held after all
        else if (accept)
          state_next = fifo_demo_pkg::IDLE; // release only rearms
    endcase
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state <= fifo_demo_pkg::IDLE;
      pulse <= 1'b0;
    end
    else
    begin
      state <= state_next;
      pulse <= accept && (state == fifo_demo_pkg::PRESS_WAIT); // entering HELD
    end
  end

endmodule

`default_nettype wire

// File: source/fifo_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_demo_defs.svh"

module fifo_ctrl (
  input  logic                          clock,
  input  logic                          reset,
  input  fifo_demo_pkg::button_events_t events,
  output logic                          wr_en,
  output logic                          rd_en,
  output logic [`FIFO_ABITS-1:0]        wr_addr,
  output logic [`FIFO_ABITS-1:0]        rd_addr,
  output fifo_demo_pkg::fifo_status_t   status
);

  // occupancy when every word is in use
  localparam logic [`FIFO_ABITS:0] depth = {1'b1, {`FIFO_ABITS{1'b0}}};

  logic [`FIFO_ABITS-1:0]  wr_ptr;   // next slot to write
  logic [`FIFO_ABITS-1:0]  rd_ptr;   // current head
  logic [`FIFO_ABITS:0]    count;    // words held, one bit wider than the pointers
  logic                    empty;
  logic                    full;
  logic                    push_ok;
  logic                    pop_ok;
  fifo_demo_pkg::fifo_op_t op;

  assign empty = (count == '0);
  assign full  = (count == depth);

  // a pop needs a stored word and a push on full needs a pop beside it
  assign pop_ok  = events.pop && !empty;
  assign push_ok = events.push && (!full || pop_ok);

  always_comb
  begin
    unique case ({pop_ok, push_ok})
      2'b01:   op = fifo_demo_pkg::OP_PUSH;
      2'b10:   op = fifo_demo_pkg::OP_POP;
      2'b11:   op = fifo_demo_pkg::OP_PUSH_POP;
      default: op = fifo_demo_pkg::OP_NONE;
    endcase
  end

  assign wr_en   = (op == fifo_demo_pkg::OP_PUSH) || (op == fifo_demo_pkg::OP_PUSH_POP);
  assign rd_en   = (op == fifo_demo_pkg::OP_POP)  || (op == fifo_demo_pkg::OP_PUSH_POP);
  assign wr_addr = wr_ptr;
  assign rd_addr = rd_ptr;

  // pointers wrap naturally at 2**FIFO_ABITS
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      unique case (op)
        fifo_demo_pkg::OP_PUSH:
        begin
          wr_ptr <= wr_ptr + 1'b1;
          count  <= count + 1'b1;
        end
        fifo_demo_pkg::OP_POP:
        begin
          rd_ptr <= rd_ptr + 1'b1;
          count  <= count - 1'b1;
        end
        fifo_demo_pkg::OP_PUSH_POP:
        begin
          wr_ptr <= wr_ptr + 1'b1; // count stays put
          rd_ptr <= rd_ptr + 1'b1;
        end
        default:
        begin
          count <= count;
        end
      endcase
    end
  end

  always_comb
  begin
    status.empty = empty;
    status.full  = full;
    status.count = count;
  end

endmodule

`default_nettype wire

// File: source/fifo_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_demo_defs.svh"

module fifo_ram (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   wr_en,
  input  logic                   rd_en,
  input  logic [`FIFO_ABITS-1:0] wr_addr,
  input  logic [`FIFO_ABITS-1:0] rd_addr,
  input  logic [`FIFO_DBITS-1:0] wr_data,
  output logic [`FIFO_DBITS-1:0] rd_data // last word read, held between pops
);

  logic [`FIFO_DBITS-1:0] mem [2**`FIFO_ABITS]; // inferred as distributed or block ram

  always_ff @(posedge clock)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // same address read and write gives the old word, which is the head on a full push-pop
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      rd_data <= '0;
    else if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: source/fifo_demo_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_demo_defs.svh"

module fifo_demo_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   btn_write, // push button
  input  logic                   btn_read,  // pop button
  input  logic [`FIFO_DBITS-1:0] data_in,   // switches
  output logic [`FIFO_DBITS-1:0] data_out,  // leds
  output logic                   empty_led,
  output logic                   full_led,
  output logic                   ready_led  // lights once out of reset
);

  fifo_demo_pkg::button_events_t events;
  fifo_demo_pkg::fifo_status_t   status;
  logic                          wr_en;
  logic                          rd_en;
  logic [`FIFO_ABITS-1:0]        wr_addr;
  logic [`FIFO_ABITS-1:0]        rd_addr;

  button_oneshot write_oneshot_i (
    .clock  (clock),
    .reset  (reset),
    .button (btn_write),
    .pulse  (events.push)
  );

  button_oneshot read_oneshot_i (
    .clock  (clock),
    .reset  (reset),
    .button (btn_read),
    .pulse  (events.pop)
  );

  fifo_ctrl fifo_ctrl_i (
    .clock   (clock),
    .reset   (reset),
    .events  (events),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .status  (status)
  );

  fifo_ram fifo_ram_i (
    .clock   (clock),
    .reset   (reset),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_data (data_in), // switches go straight to the write port
    .rd_data (data_out)
  );

  assign empty_led = status.empty;
  assign full_led  = status.full;

  // set on the first edge after reset lets go
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      ready_led <= 1'b0;
    else
      ready_led <= 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  // 20 ns period, first rising edge at 10 ns
  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // held through three rising edges, dropped on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: bench/fifo_ctrl_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_demo_defs.svh"

module fifo_ctrl_properties (
  input logic                          clock,
  input logic                          reset,
  input fifo_demo_pkg::button_events_t events,
  input logic                          wr_en,
  input logic                          rd_en,
  input fifo_demo_pkg::fifo_status_t   status
);

  localparam logic [`FIFO_ABITS:0] depth = {1'b1, {`FIFO_ABITS{1'b0}}};

  int failures = 0; // bumped by every failing property

  flags_exclusive: assert property (@(posedge clock) disable iff (reset)
    !(status.empty && status.full))
  else
  begin
    $error("empty and full are set together");
    failures++;
  end

  empty_matches_count: assert property (@(posedge clock) disable iff (reset)
    status.empty == (status.count == '0))
  else
  begin
    $error("empty flag disagrees with the occupancy count");
    failures++;
  end

  full_matches_count: assert property (@(posedge clock) disable iff (reset)
    status.full == (status.count == depth))
  else
  begin
    $error("full flag disagrees with the occupancy count");
    failures++;
  end

  // a write on full is only legal as half of a push-pop
  no_write_on_full: assert property (@(posedge clock) disable iff (reset)
    (wr_en && status.full) |-> rd_en)
  else
  begin
    $error("write enable while full without a read");
    failures++;
  end

  single_cycle_push: assert property (@(posedge clock) disable iff (reset)
    events.push |=> !events.push)
  else
  begin
    $error("push pulse wider than one clock");
    failures++;
  end

  single_cycle_pop: assert property (@(posedge clock) disable iff (reset)
    events.pop |=> !events.pop)
  else
  begin
    $error("pop pulse wider than one clock");
    failures++;
  end

endmodule

`default_nettype wire

// File: bench/fifo_demo_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "fifo_demo_defs.svh"

module fifo_demo_tb;

  localparam int depth      = 2**`FIFO_ABITS;
  localparam int settle     = `DEBOUNCE_CYCLES + `SYNC_STAGES + 4; // latency plus margin
  localparam int wait_limit = 100;

  logic                   clock;
  logic                   reset;
  logic                   btn_write;
  logic                   btn_read;
  logic [`FIFO_DBITS-1:0] data_in;
  logic [`FIFO_DBITS-1:0] data_out;
  logic                   empty_led;
  logic                   full_led;
  logic                   ready_led;

  logic [`FIFO_DBITS-1:0] model [$]; // expected contents, head first
  int                     value_errors;
  int                     timeout_errors;
  int                     assert_errors;

  clock_gen clock_gen_i (
    .clock (clock),
    .reset (reset)
  );

  fifo_demo_top fifo_demo_top_i (
    .clock     (clock),
    .reset     (reset),
    .btn_write (btn_write),
    .btn_read  (btn_read),
    .data_in   (data_in),
    .data_out  (data_out),
    .empty_led (empty_led),
    .full_led  (full_led),
    .ready_led (ready_led)
  );

  bind fifo_ctrl fifo_ctrl_properties fifo_ctrl_properties_i (
    .clock  (clock),
    .reset  (reset),
    .events (events),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .status (status)
  );

  task automatic check_value(input string name, input int expected, input int actual);
    assert (actual == expected)
    else
    begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      value_errors++;
    end
  endtask

  function automatic logic led_value(input int sel);
    case (sel)
      0:       led_value = empty_led;
      1:       led_value = full_led;
      default: led_value = ready_led;
    endcase
  endfunction

  task automatic wait_led(input string name, input int sel, input logic want);
    int n;
    n = 0;
    while (led_value(sel) !== want && n < wait_limit)
    begin
      @(negedge clock);
      n++;
    end
    if (led_value(sel) !== want)
    begin
      $display("timeout: %s did not reach %0b within %0d cycles", name, want, wait_limit);
      timeout_errors++;
    end
  endtask

  // hold one button, then let go long enough for the release to settle
  task automatic press(input logic write, input int cycles);
    if (write)
      btn_write = 1'b1;
    else
      btn_read = 1'b1;
    repeat (cycles) @(negedge clock);
    btn_write = 1'b0;
    btn_read  = 1'b0;
    repeat (settle) @(negedge clock);
  endtask

  task automatic push_word(input int cycles);
    data_in = `FIFO_DBITS'($urandom());
    if (model.size() < depth)
      model.push_back(data_in); // a push on full is dropped
    press(1'b1, cycles);
  endtask

  task automatic pop_word(input string name);
    logic [`FIFO_DBITS-1:0] expected;
    expected = data_out; // an empty pop leaves the output alone
    if (model.size() > 0)
      expected = model.pop_front();
    press(1'b0, settle);
    check_value(name, expected, data_out);
  endtask

  initial
  begin
    int i;
    btn_write      = 1'b0;
    btn_read       = 1'b0;
    data_in        = '0;
    value_errors   = 0;
    timeout_errors = 0;
    void'($urandom(8));

    @(negedge clock); // reset still high here
    check_value("reset ready_led", 0, ready_led);
    wait_led("ready_led", 2, 1'b1);
    check_value("reset empty_led", 1, empty_led);
    check_value("reset full_led", 0, full_led);
    check_value("reset data_out", 0, data_out);

    for (i = 0; i < 5; i++)
      push_word(settle);
    wait_led("empty_led after pushes", 0, 1'b0);
    for (i = 0; i < 5; i++)
      pop_word($sformatf("order pop %0d", i));
    wait_led("empty_led after order pops", 0, 1'b1);

    for (i = 0; i < depth; i++)
      push_word(settle);
    wait_led("full_led", 1, 1'b1);
    push_word(settle); // one too many
    check_value("overflow full_led", 1, full_led);
    for (i = 0; i < depth; i++)
      pop_word($sformatf("overflow pop %0d", i));
    wait_led("empty_led after draining", 0, 1'b1);
    check_value("drained full_led", 0, full_led);

    pop_word("underflow data_out");
    check_value("underflow empty_led", 1, empty_led);

    // bounces shorter than the debounce count
    for (i = 0; i < 3; i++)
    begin
      btn_write = 1'b1;
      repeat (`DEBOUNCE_CYCLES / 2) @(negedge clock);
      btn_write = 1'b0;
      repeat (`DEBOUNCE_CYCLES / 2) @(negedge clock);
    end
    repeat (settle) @(negedge clock);
    check_value("glitch empty_led", 1, empty_led);
    push_word(10 * `DEBOUNCE_CYCLES);
    wait_led("empty_led after long press", 0, 1'b0);
    pop_word("long press pop");
    check_value("long press empty_led", 1, empty_led);

    assert_errors = fifo_demo_top_i.fifo_ctrl_i.fifo_ctrl_properties_i.failures;
    $display("errors: value %0d, timeout %0d, assertion %0d",
             value_errors, timeout_errors, assert_errors);
    if (value_errors + timeout_errors + assert_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/fifo_demo_pkg.sv
source/debounce_timer.sv
source/button_oneshot.sv
source/fifo_ctrl.sv
source/fifo_ram.sv
source/fifo_demo_top.sv
bench/clock_gen.sv
bench/fifo_ctrl_properties.sv
bench/fifo_demo_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = fifo_demo_tb
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "make clean  remove $(BUILD) and $(LOG)"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS)' $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
